// File: Bender.yml
package:
  name: scpad_backend

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/scpad_cmd_pkg.sv
      - hdl/scpad_mem_pkg.sv
      - hdl/burst_sequencer.sv
      - hdl/swizzle.sv
      - hdl/beat_router.sv
      - hdl/beat_fifo.sv
      - hdl/backend.sv
      - target: test
        files:
          - verification/tb_clock.sv
          - verification/backend_asserts.sv
          - verification/backend_tb.sv

// File: hdl/backend.sv
`include "scpad_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module backend (
    input  logic                      bshif,
    input  logic                      arst_n,
    // scheduler
    input  logic                      cmd_valid,
    input  scpad_cmd_pkg::sched_cmd_t cmd,
    output logic                      busy,
    // dram
    output scpad_mem_pkg::dram_req_t  dram_req,
    input  logic                      dram_stall,
    input  scpad_mem_pkg::dram_res_t  dram_res,
    // scratchpad
    output scpad_mem_pkg::sram_wr_t   sram_req,
    input  logic                      sram_stall
);

    localparam int bank_w = $clog2(`SCPAD_NUM_BANKS);

    scpad_mem_pkg::dram_req_t  seq_req;
    scpad_cmd_pkg::sched_cmd_t active_cmd;
    scpad_cmd_pkg::burst_tag_t res_tag;
    scpad_mem_pkg::sram_wr_t   wr_data;
    logic [bank_w-1:0] lane_base;
    logic [`SCPAD_SPAD_ADDR_W-1:0] sram_addr;
    logic seq_push;
    logic req_full;
    logic req_empty;
    logic req_pop;
    logic wr_push;
    logic wr_empty;
    logic wr_pop;

    // fifo heads leave when the stall level is low
    assign req_pop = !req_empty && !dram_stall;
    // each popped write returns a credit
    assign wr_pop = !wr_empty && !sram_stall;

    burst_sequencer u_seq (
        .bshif         (bshif),
        .arst_n        (arst_n),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .req_full      (req_full),
        .credit_return (wr_pop),
        .req_push      (seq_push),
        .req_data      (seq_req),
        .active_cmd    (active_cmd),
        .busy          (busy)
    );

    // dram read requests
    beat_fifo #(
        .payload_t (scpad_mem_pkg::dram_req_t),
        .DEPTH     (`SCPAD_REQ_DEPTH)
    ) u_req_fifo (
        .bshif     (bshif),
        .arst_n    (arst_n),
        .push      (seq_push),
        .push_data (seq_req),
        .pop       (req_pop),
        .head      (dram_req),
        .full      (req_full),
        .empty     (req_empty)
    );

    // bank mapping for the returning tag
    swizzle u_swizzle (
        .tag       (res_tag),
        .spad_base (active_cmd.spad_base),
        .lane_base (lane_base),
        .sram_addr (sram_addr)
    );

    beat_router u_router (
        .bshif     (bshif),
        .arst_n    (arst_n),
        .dram_res  (dram_res),
        .cols_m1   (active_cmd.cols_m1),
        .lane_base (lane_base),
        .sram_addr (sram_addr),
        .tag       (res_tag),
        .wr_push   (wr_push),
        .wr_data   (wr_data)
    );

    // scratchpad writes bounded by the sequencer credits
    beat_fifo #(
        .payload_t (scpad_mem_pkg::sram_wr_t),
        .DEPTH     (`SCPAD_RESP_DEPTH)
    ) u_wr_fifo (
        .bshif     (bshif),
        .arst_n    (arst_n),
        .push      (wr_push),
        .push_data (wr_data),
        .pop       (wr_pop),
        .head      (sram_req),
        .full      (),
        .empty     (wr_empty)
    );

endmodule

`default_nettype wire

// File: hdl/beat_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module beat_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH = 2
) (
    input  logic     bshif,
    input  logic     arst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     full,
    output logic     empty
);

    localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int cnt_w = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [cnt_w-1:0] count;
    logic do_push;
    logic do_pop;

    assign full = (count == cnt_w'(DEPTH));
    assign empty = (count == '0);
    // push into a full fifo only when the head leaves the same cycle
    assign do_push = push && (!full || pop);
    assign do_pop = pop && !empty;

    // valid of head is low when nothing is stored
    always_comb begin
        head = mem[rd_ptr];
        if (empty) begin
            head.valid = 1'b0;
        end
    end

    always_ff @(posedge bshif) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap at DEPTH
    always_ff @(posedge bshif or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
        end
    end

endmodule

`default_nettype wire

// File: hdl/beat_router.sv
`include "scpad_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module beat_router (
    input  logic                                  bshif,
    input  logic                                  arst_n,
    input  scpad_mem_pkg::dram_res_t              dram_res,
    input  logic [`SCPAD_COL_W-1:0]               cols_m1,
    input  logic [$clog2(`SCPAD_NUM_BANKS)-1:0]   lane_base,
    input  logic [`SCPAD_SPAD_ADDR_W-1:0]         sram_addr,
    output scpad_cmd_pkg::burst_tag_t             tag,
    output logic                                  wr_push,
    output scpad_mem_pkg::sram_wr_t               wr_data
);

    logic [`SCPAD_BEAT_ELEMS-1:0] lane_mask;
    scpad_mem_pkg::sram_wr_t next_wr;

    // tag goes out to swizzle, answer comes back same cycle
    assign tag = dram_res.tag;

    // element e of burst s is column 4*s + e
    // keep it only if inside the row
    always_comb begin
        for (int e = 0; e < `SCPAD_BEAT_ELEMS; e++) begin
            lane_mask[e] = (int'(dram_res.tag.sub) * `SCPAD_BEAT_ELEMS + e) <= int'(cols_m1);
        end
    end

    // assemble the write
    always_comb begin
        next_wr.valid = 1'b1;
        next_wr.addr = sram_addr;
        next_wr.lane_base = lane_base;
        next_wr.mask = lane_mask;
        // data goes through untouched, lanes are picked by the mask
        next_wr.wdata = dram_res.rdata;
    end

    // push pulse, one cycle after the response
    always_ff @(posedge bshif or negedge arst_n) begin
        if (!arst_n) begin
            wr_push <= 1'b0;
        end else begin
            wr_push <= dram_res.valid;
        end
    end

    // payload only loads on a response
    always_ff @(posedge bshif) begin
        if (dram_res.valid) begin
            wr_data <= next_wr;
        end
    end

endmodule

`default_nettype wire

// File: hdl/burst_sequencer.sv
`include "scpad_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module burst_sequencer (
    input  logic                      bshif,
    input  logic                      arst_n,
    input  logic                      cmd_valid,
    input  scpad_cmd_pkg::sched_cmd_t cmd,
    input  logic                      req_full,
    input  logic                      credit_return,
    output logic                      req_push,
    output scpad_mem_pkg::dram_req_t  req_data,
    output scpad_cmd_pkg::sched_cmd_t active_cmd,
    output logic                      busy
);

    localparam int beat_bytes = `SCPAD_ELEM_W * `SCPAD_BEAT_ELEMS / 8;
    localparam int byte_shift = $clog2(beat_bytes);
    localparam int cnt_w = `SCPAD_ROW_W + `SCPAD_SUB_W + 1;
    localparam int credit_w = $clog2(`SCPAD_RESP_DEPTH + 1);

    scpad_cmd_pkg::sched_cmd_t cmd_q;
    scpad_cmd_pkg::burst_tag_t req_tag;
    logic [`SCPAD_ROW_W-1:0] row;
    logic [`SCPAD_SUB_W-1:0] sub;
    logic [`SCPAD_SUB_W-1:0] subs_m1;
    logic issuing;
    logic [credit_w-1:0] credit_cnt;
    logic [cnt_w-1:0] done_cnt;
    logic [cnt_w-1:0] total_bursts;
    logic cmd_accept;
    logic last_return;

    // bursts per row minus one, cols_m1 / 4
    assign subs_m1 = `SCPAD_SUB_W'(cmd_q.cols_m1 >> $clog2(`SCPAD_BEAT_ELEMS));
    assign total_bursts = cnt_w'(cmd_q.rows_m1 + 1) * cnt_w'(subs_m1 + 1);

    assign cmd_accept = cmd_valid && !busy;
    // issue only with fifo room and a free credit
    assign req_push = busy && issuing && !req_full && (credit_cnt < `SCPAD_RESP_DEPTH);
    assign last_return = credit_return && (done_cnt == total_bursts - 1'b1);

    assign req_tag.row = row;
    assign req_tag.sub = sub;

    // {row, sub} times 8 gives 64*row + 8*sub
    always_comb begin
        req_data.valid = req_push;
        req_data.tag = req_tag;
        req_data.addr = cmd_q.dram_base + (`SCPAD_DRAM_ADDR_W'(req_tag) << byte_shift);
        req_data.num_bytes = 4'(beat_bytes);
    end

    assign active_cmd = cmd_q;

    // command capture
    always_ff @(posedge bshif) begin
        if (cmd_accept) begin
            cmd_q <= cmd;
        end
    end

    // row/sub walk, sub runs fastest
    always_ff @(posedge bshif or negedge arst_n) begin
        if (!arst_n) begin
            row <= '0;
            sub <= '0;
            issuing <= 1'b0;
        end else if (cmd_accept) begin
            row <= '0;
            sub <= '0;
            issuing <= 1'b1;
        end else if (req_push) begin
            if (sub == subs_m1) begin
                sub <= '0;
                row <= row + 1'b1;
                // last row done
                if (row == cmd_q.rows_m1) begin
                    issuing <= 1'b0;
                end
            end else begin
                sub <= sub + 1'b1;
            end
        end
    end

    // reads in flight plus writes not yet popped
    always_ff @(posedge bshif or negedge arst_n) begin
        if (!arst_n) begin
            credit_cnt <= '0;
        end else begin
            credit_cnt <= credit_cnt + credit_w'(req_push) - credit_w'(credit_return);
        end
    end

    // completion count, busy drops after the last pop
    always_ff @(posedge bshif or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            done_cnt <= '0;
        end else if (cmd_accept) begin
            busy <= 1'b1;
            done_cnt <= '0;
        end else if (credit_return) begin
            done_cnt <= done_cnt + 1'b1;
            if (last_return) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/scpad_cmd_pkg.sv
`include "scpad_settings.svh"
`default_nettype none

package scpad_cmd_pkg;

    // scheduler load command, sampled on the cmd_valid pulse
    typedef struct packed {
        // byte address of row 0 in dram
        logic [`SCPAD_DRAM_ADDR_W-1:0] dram_base;
        // scratchpad row address of row 0
        logic [`SCPAD_SPAD_ADDR_W-1:0] spad_base;
        // row count minus one
        logic [`SCPAD_ROW_W-1:0] rows_m1;
        // column count minus one, in elements
        logic [`SCPAD_COL_W-1:0] cols_m1;
    } sched_cmd_t;

    // dram transaction id
    // row index in the upper bits, burst within the row below
    typedef struct packed {
        logic [`SCPAD_ROW_W-1:0] row;
        logic [`SCPAD_SUB_W-1:0] sub;
    } burst_tag_t;

endpackage

`default_nettype wire

// File: hdl/scpad_mem_pkg.sv
`include "scpad_settings.svh"
`default_nettype none

package scpad_mem_pkg;

    // one dram read burst
    typedef struct packed {
        logic valid;
        scpad_cmd_pkg::burst_tag_t tag;
        logic [`SCPAD_DRAM_ADDR_W-1:0] addr;
        // always a full 8 byte burst
        logic [3:0] num_bytes;
    } dram_req_t;

    // dram read data, one cycle pulse per response
    typedef struct packed {
        logic valid;
        scpad_cmd_pkg::burst_tag_t tag;
        logic [`SCPAD_ELEM_W*`SCPAD_BEAT_ELEMS-1:0] rdata;
    } dram_res_t;

    // scratchpad write of one burst
    typedef struct packed {
        logic valid;
        // row address
        logic [`SCPAD_SPAD_ADDR_W-1:0] addr;
        // bank that takes element 0
        logic [$clog2(`SCPAD_NUM_BANKS)-1:0] lane_base;
        // one bit per element, low bits for partial bursts
        logic [`SCPAD_BEAT_ELEMS-1:0] mask;
        logic [`SCPAD_ELEM_W*`SCPAD_BEAT_ELEMS-1:0] wdata;
    } sram_wr_t;

endpackage

`default_nettype wire

// File: hdl/scpad_settings.svh
`ifndef SCPAD_SETTINGS_SVH
`define SCPAD_SETTINGS_SVH
`default_nettype none

// command geometry
`define SCPAD_ROW_W 5
`define SCPAD_COL_W 5
`define SCPAD_SUB_W 3

// one burst is four 16 bit elements, 8 bytes
`define SCPAD_ELEM_W 16
`define SCPAD_BEAT_ELEMS 4
`define SCPAD_NUM_BANKS 32

// address widths
`define SCPAD_DRAM_ADDR_W 32
`define SCPAD_SPAD_ADDR_W 20

// write fifo depth doubles as the credit limit
`define SCPAD_REQ_DEPTH 2
`define SCPAD_RESP_DEPTH 4

`default_nettype wire
`endif

// File: hdl/swizzle.sv
`include "scpad_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module swizzle (
    input  scpad_cmd_pkg::burst_tag_t             tag,
    input  logic [`SCPAD_SPAD_ADDR_W-1:0]         spad_base,
    output logic [$clog2(`SCPAD_NUM_BANKS)-1:0]   lane_base,
    output logic [`SCPAD_SPAD_ADDR_W-1:0]         sram_addr
);

    localparam int bank_w = $clog2(`SCPAD_NUM_BANKS);

    // bank of element 0 before rotation
    logic [bank_w-1:0] col_bank;
    // per-row rotation amount
    logic [bank_w-1:0] row_rot;

    // burst s starts at column 4*s
    assign col_bank = bank_w'(tag.sub) * bank_w'(`SCPAD_BEAT_ELEMS);

    // rotate by row index so column c of
    // neighbouring rows lands in different banks
    assign row_rot = bank_w'(tag.row);

    // wraps mod bank count, banks are a power of two
    assign lane_base = col_bank + row_rot;

    // one scratchpad row per matrix row
    assign sram_addr = spad_base + `SCPAD_SPAD_ADDR_W'(tag.row);

endmodule

`default_nettype wire

// File: project.f
+incdir+hdl
hdl/scpad_cmd_pkg.sv
hdl/scpad_mem_pkg.sv
hdl/burst_sequencer.sv
hdl/swizzle.sv
hdl/beat_router.sv
hdl/beat_fifo.sv
hdl/backend.sv
verification/tb_clock.sv
verification/backend_asserts.sv
verification/backend_tb.sv

// File: verification/backend_asserts.sv
`include "scpad_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module backend_asserts (
    input logic                     bshif,
    input logic                     arst_n,
    input logic                     busy,
    input scpad_mem_pkg::dram_req_t dram_req,
    input logic                     dram_stall,
    input scpad_mem_pkg::sram_wr_t  sram_req,
    input logic                     sram_stall,
    input logic                     seq_push,
    input logic                     wr_pop
);

    // count of failed assertions
    int fail_count = 0;
    // reads issued minus writes popped
    int credits;

    always_ff @(posedge bshif or negedge arst_n) begin
        if (!arst_n) begin
            credits <= 0;
        end else begin
            credits <= credits + int'(seq_push) - int'(wr_pop);
        end
    end

    // stalled request holds its content
    dram_hold: assert property (@(posedge bshif) disable iff (!arst_n)
        dram_req.valid && dram_stall |=> $stable(dram_req))
        else begin
            fail_count++;
            $error("dram request changed while stalled");
        end

    // same for the scratchpad write
    sram_hold: assert property (@(posedge bshif) disable iff (!arst_n)
        sram_req.valid && sram_stall |=> $stable(sram_req))
        else begin
            fail_count++;
            $error("sram write changed while stalled");
        end

    credit_limit: assert property (@(posedge bshif) disable iff (!arst_n)
        credits <= `SCPAD_RESP_DEPTH)
        else begin
            fail_count++;
            $error("more bursts outstanding than the write fifo holds");
        end

    // outputs idle while reset is held
    reset_idle: assert property (@(posedge bshif)
        !arst_n |-> !busy && !dram_req.valid && !sram_req.valid)
        else begin
            fail_count++;
            $error("busy or a valid output high during reset");
        end

endmodule

`default_nettype wire

// File: verification/backend_tb.sv
`include "scpad_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module backend_tb;

    localparam int num_cmds = 40;
    // commands * rows * bursts per row * slack for stalls and dram latency
    localparam int cycle_limit = num_cmds * 32 * 8 * 24;

    logic bshif;
    logic arst_n;
    logic cmd_valid;
    scpad_cmd_pkg::sched_cmd_t cmd;
    logic busy;
    scpad_mem_pkg::dram_req_t dram_req;
    logic dram_stall;
    scpad_mem_pkg::dram_res_t dram_res;
    scpad_mem_pkg::sram_wr_t sram_req;
    logic sram_stall;

    // lfsr state seeded with 26
    logic [15:0] lfsr = 16'd26;
    int cycle;
    // model copy of the accepted command
    scpad_cmd_pkg::sched_cmd_t cur;
    int next_row;
    int next_sub;
    int issued;
    int written;
    int total;
    bit active;
    bit done_seen;
    // reads taken by the dram model awaiting an answer
    scpad_cmd_pkg::burst_tag_t pend_tag[$];
    int pend_due[$];
    // writes owed to the scratchpad in response order
    scpad_mem_pkg::sram_wr_t exp_wr_q[$];

    tb_clock u_clk (
        .bshif  (bshif),
        .arst_n (arst_n)
    );

    backend DUT (
        .bshif      (bshif),
        .arst_n     (arst_n),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .busy       (busy),
        .dram_req   (dram_req),
        .dram_stall (dram_stall),
        .dram_res   (dram_res),
        .sram_req   (sram_req),
        .sram_stall (sram_stall)
    );

    bind backend backend_asserts u_asserts (
        .bshif      (bshif),
        .arst_n     (arst_n),
        .busy       (busy),
        .dram_req   (dram_req),
        .dram_stall (dram_stall),
        .sram_req   (sram_req),
        .sram_stall (sram_stall),
        .seq_push   (seq_push),
        .wr_pop     (wr_pop)
    );

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
        end
        return val;
    endfunction

    function automatic scpad_cmd_pkg::sched_cmd_t random_cmd();
        scpad_cmd_pkg::sched_cmd_t c;
        c.dram_base = rand_bits(32);
        c.spad_base = 20'(rand_bits(20));
        c.rows_m1 = 5'(rand_bits(5));
        c.cols_m1 = 5'(rand_bits(5));
        return c;
    endfunction

    // dram_base + 64*r + 8*s
    function automatic logic [31:0] burst_addr(input int r, input int s);
        return cur.dram_base + 32'(64 * r + 8 * s);
    endfunction

    // memory content derived from the whole address
    function automatic logic [63:0] data_for(input logic [31:0] addr);
        return {addr ^ 32'hc3a5_5a3c, ~addr};
    endfunction

    function automatic scpad_mem_pkg::sram_wr_t expected_write(
        input scpad_cmd_pkg::burst_tag_t t
    );
        scpad_mem_pkg::sram_wr_t w;
        w.valid = 1'b1;
        w.addr = cur.spad_base + 20'(t.row);
        w.lane_base = 5'((4 * int'(t.sub) + int'(t.row)) % 32);
        // lane e holds column 4*s + e
        for (int e = 0; e < 4; e++) begin
            w.mask[e] = (4 * int'(t.sub) + e) <= int'(cur.cols_m1);
        end
        w.wdata = data_for(burst_addr(int'(t.row), int'(t.sub)));
        return w;
    endfunction

    task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
        if (exp !== act) begin
            $display("error %s expected %0h actual %0h", name, exp, act);
            $display("Finished with errors");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // drive after the edge and sample just before the next one
    task automatic tick(input logic send, input scpad_cmd_pkg::sched_cmd_t c);
        int pick;
        scpad_mem_pkg::dram_req_t exp_req;
        @(posedge bshif);
        #1;
        cycle++;
        if (cycle > cycle_limit) begin
            $display("timeout after %0d cycles, the backend stopped making progress", cycle);
            $display("Finished with errors");
            $fatal(1, "timeout");
        end
        if (DUT.u_asserts.fail_count != 0) begin
            $display("a bound assertion failed at cycle %0d", cycle);
            $display("Finished with errors");
            $fatal(1, "assertion failure");
        end
        cmd_valid = send;
        cmd = c;
        // about 25 % stall each
        dram_stall = (rand_bits(2) == 0);
        sram_stall = (rand_bits(2) == 0);
        dram_res = '0;
        // dram model answers a random pending read once its delay is over
        if (pend_tag.size() > 0) begin
            pick = int'(rand_bits(3)) % pend_tag.size();
            if (pend_due[pick] <= cycle) begin
                dram_res.valid = 1'b1;
                dram_res.tag = pend_tag[pick];
                dram_res.rdata = data_for(burst_addr(int'(pend_tag[pick].row),
                                                     int'(pend_tag[pick].sub)));
                exp_wr_q.push_back(expected_write(pend_tag[pick]));
                pend_tag.delete(pick);
                pend_due.delete(pick);
            end
        end
        #6;
        // busy stays high until the cycle after the last pop
        if (active) begin
            if (done_seen) begin
                check("busy_fall", 0, busy);
                check("scoreboard_empty", 0, pend_tag.size() + exp_wr_q.size());
                check("request_total", total, issued);
                active = 0;
            end else begin
                check("busy_high", 1, busy);
            end
        end
        // request leaves at the next edge
        if (dram_req.valid && !dram_stall) begin
            check("request_in_range", 1, issued < total);
            exp_req.valid = 1'b1;
            exp_req.tag.row = 5'(next_row);
            exp_req.tag.sub = 3'(next_sub);
            exp_req.addr = burst_addr(next_row, next_sub);
            exp_req.num_bytes = 4'd8;
            check("dram_request", exp_req, dram_req);
            pend_tag.push_back(dram_req.tag);
            pend_due.push_back(cycle + 1 + int'(rand_bits(4)));
            issued++;
            // sub runs fastest
            if (next_sub == int'(cur.cols_m1) / 4) begin
                next_sub = 0;
                next_row++;
            end else begin
                next_sub++;
            end
        end
        // write popped at the next edge
        if (sram_req.valid && !sram_stall) begin
            check("write_expected", 1, exp_wr_q.size() > 0);
            check("sram_write", exp_wr_q.pop_front(), sram_req);
            written++;
            if (written == total) begin
                done_seen = 1;
            end
        end
    endtask

    initial begin
        cmd_valid = 1'b0;
        cmd = '0;
        dram_stall = 1'b0;
        sram_stall = 1'b0;
        dram_res = '0;
        cycle = 0;
        active = 0;
        done_seen = 0;
        @(posedge arst_n);
        check("busy_after_reset", 0, busy);
        for (int k = 0; k < num_cmds; k++) begin
            cur = random_cmd();
            next_row = 0;
            next_sub = 0;
            issued = 0;
            written = 0;
            done_seen = 0;
            total = (int'(cur.rows_m1) + 1) * (int'(cur.cols_m1) / 4 + 1);
            tick(1'b1, cur);
            check("busy_before_accept", 0, busy);
            active = 1;
            // second pulse lands while busy and must be dropped
            tick(1'b1, random_cmd());
            while (active) begin
                tick(1'b0, '0);
            end
        end
        if (DUT.u_asserts.fail_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("%0d assertion failures during the run", DUT.u_asserts.fail_count);
            $display("Finished with errors");
            $fatal(1, "assertion failures");
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic bshif,
    output logic arst_n
);

    // 8 ns period, starts low
    initial begin
        bshif = 1'b0;
        forever #4 bshif = ~bshif;
    end

    // reset held over 8 rising edges, released with the stimulus offset
    initial begin
        arst_n = 1'b0;
        repeat (8) @(posedge bshif);
        #1 arst_n = 1'b1;
    end

endmodule

`default_nettype wire
